//--- Bender.yml
package:
  name: redmule_tile

sources:
  - hdl/redmule_pkg.sv
  - hdl/redmule_stream_fifo.sv
  - hdl/redmule_engine.sv
  - hdl/redmule_scheduler.sv
  - hdl/redmule_ctrl.sv
  - hdl/redmule_top.sv
  - target: test
    files:
      - verification/tb_redmule.sv

//--- hdl/redmule_ctrl.sv
// APB register file of the tile, zero wait states.
// A trigger write while busy is refused with pslverr_o and starts nothing.
// Writing 0 to the depth register stores 1. Only the low KLEN_W bits are kept.

`timescale 1ns/1ps

module redmule_ctrl
  import redmule_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [APB_ADDR_W-1:0] paddr_i,
  input  logic [APB_DATA_W-1:0] pwdata_i,
  input  logic                  job_done_i,
  output logic [APB_DATA_W-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  output logic                  start_o,
  output logic [KLEN_W-1:0]     k_len_o,
  output logic                  evt_o
);

  logic              access;
  logic              addr_hit;
  logic              klen_wr;
  logic              trig_ok;
  logic [KLEN_W-1:0] k_len_q;
  logic              busy_q;
  logic              start_q;
  logic              evt_q;

  // Access phase of an APB transfer
  assign access = psel_i & penable_i;

  always_comb begin
    addr_hit = 1'b1;
    prdata_o = '0;
    case (paddr_i)
      REG_KLEN:    prdata_o = {{(APB_DATA_W-KLEN_W){1'b0}}, k_len_q};
      REG_STATUS:  prdata_o = {{(APB_DATA_W-1){1'b0}}, busy_q};
      REG_TRIGGER: prdata_o = '0;
      default:     addr_hit = 1'b0;
    endcase
  end

  assign pready_o  = access;
  assign pslverr_o = access & (~addr_hit
                               | (pwrite_i & (paddr_i == REG_STATUS))
                               | (pwrite_i & (paddr_i == REG_TRIGGER) & busy_q));

  assign klen_wr = access & pwrite_i & (paddr_i == REG_KLEN);
  assign trig_ok = access & pwrite_i & (paddr_i == REG_TRIGGER) & ~busy_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      k_len_q <= KLEN_W'(1);
      busy_q  <= 1'b0;
      start_q <= 1'b0;
      evt_q   <= 1'b0;
    end else begin
      start_q <= trig_ok;
      evt_q   <= job_done_i;
      if (trig_ok) begin
        busy_q <= 1'b1;
      end else if (job_done_i) begin
        busy_q <= 1'b0;
      end
      if (klen_wr) begin
        k_len_q <= (pwdata_i[KLEN_W-1:0] == '0) ? KLEN_W'(1) : pwdata_i[KLEN_W-1:0];
      end
    end
  end

  assign start_o = start_q;
  assign k_len_o = k_len_q;
  assign evt_o   = evt_q;

  // The scheduler finishes only jobs that this block started
  a_done_while_busy : assert property (@(posedge clk_i) disable iff (reset_i)
    job_done_i |-> busy_q);

endmodule : redmule_ctrl

//--- hdl/redmule_engine.sv
// ROWS signed 8x8 multiply-accumulate lanes with 24-bit wrapping accumulators.
// The W weight is shared by all rows. Row 0 sits in the low bits of X, Y and Z.

`timescale 1ns/1ps

module redmule_engine
  import redmule_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  input  engine_op_e        eng_op_i,
  input  logic [X_W-1:0]    x_data_i,
  input  logic [ELEM_W-1:0] w_data_i,
  input  logic [YZ_W-1:0]   y_data_i,
  output logic [YZ_W-1:0]   z_data_o
);

  logic        [ROWS-1:0][ACC_W-1:0] acc_q;
  logic signed [2*ELEM_W-1:0]        prod [ROWS];
  logic        [ROWS-1:0][ACC_W-1:0] prod_ext;

  // Signed products, sign extended to the accumulator width
  always_comb begin
    for (int r = 0; r < ROWS; r++) begin
      prod[r]     = $signed(x_data_i[r*ELEM_W +: ELEM_W]) * $signed(w_data_i);
      prod_ext[r] = {{(ACC_W-2*ELEM_W){prod[r][2*ELEM_W-1]}}, prod[r]};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      acc_q <= '0;
    end else begin
      case (eng_op_i)
        ENG_LOAD: acc_q <= y_data_i;
        ENG_MAC: begin
          // Plain addition wraps modulo 2^ACC_W
          for (int r = 0; r < ROWS; r++) begin
            acc_q[r] <= acc_q[r] + prod_ext[r];
          end
        end
        default: acc_q <= acc_q;
      endcase
    end
  end

  assign z_data_o = acc_q;

endmodule : redmule_engine

//--- hdl/redmule_pkg.sv
// Shared sizes, APB register map and enums for the integer MAC tile.
// The tile has a fixed ROWS; changing it also changes the X, Y and Z beat widths.
// Accumulators wrap modulo 2^ACC_W. Overflow is not flagged.

package redmule_pkg;

  // Tile geometry
  localparam int unsigned ROWS   = 4;
  localparam int unsigned ELEM_W = 8;
  localparam int unsigned ACC_W  = 24;
  localparam int unsigned X_W    = ROWS * ELEM_W;
  localparam int unsigned YZ_W   = ROWS * ACC_W;

  // Depth register width, so K runs from 1 to 255
  localparam int unsigned KLEN_W = 8;

  localparam int unsigned IN_FIFO_DEPTH  = 4;
  localparam int unsigned OUT_FIFO_DEPTH = 2;

  // APB slave
  localparam int unsigned APB_ADDR_W = 8;
  localparam int unsigned APB_DATA_W = 32;

  localparam logic [APB_ADDR_W-1:0] REG_KLEN    = 8'h00;
  localparam logic [APB_ADDR_W-1:0] REG_STATUS  = 8'h04;
  localparam logic [APB_ADDR_W-1:0] REG_TRIGGER = 8'h54;

  typedef enum logic [1:0] {
    S_IDLE,
    S_LOAD_BIAS,
    S_ACCUMULATE,
    S_STORE
  } sched_state_e;

  typedef enum logic [1:0] {
    ENG_HOLD,
    ENG_LOAD,
    ENG_MAC
  } engine_op_e;

endpackage : redmule_pkg

//--- hdl/redmule_scheduler.sv
// Job FSM: one Y beat, then K paired X/W steps, then one Z beat.
// K is sampled at start, so a depth write during a job affects the next job only.
// A step needs both the X and W FIFOs valid in the same cycle.

`timescale 1ns/1ps

module redmule_scheduler
  import redmule_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              start_i,
  input  logic [KLEN_W-1:0] k_len_i,
  input  logic              x_valid_i,
  input  logic              w_valid_i,
  input  logic              y_valid_i,
  input  logic              z_ready_i,
  output logic              x_pop_o,
  output logic              w_pop_o,
  output logic              y_pop_o,
  output logic              z_push_o,
  output engine_op_e        eng_op_o,
  output logic              job_done_o
);

  sched_state_e      state_q;
  sched_state_e      state_d;
  logic [KLEN_W-1:0] k_len_q;
  logic [KLEN_W-1:0] step_cnt_q;
  logic              step;

  assign step = (state_q == S_ACCUMULATE) & x_valid_i & w_valid_i;

  always_comb begin
    state_d    = state_q;
    y_pop_o    = 1'b0;
    z_push_o   = 1'b0;
    job_done_o = 1'b0;
    eng_op_o   = ENG_HOLD;
    case (state_q)
      S_IDLE: begin
        if (start_i) state_d = S_LOAD_BIAS;
      end
      S_LOAD_BIAS: begin
        y_pop_o = y_valid_i;
        if (y_valid_i) begin
          eng_op_o = ENG_LOAD;
          state_d  = S_ACCUMULATE;
        end
      end
      S_ACCUMULATE: begin
        if (step) begin
          eng_op_o = ENG_MAC;
          // Last step of the job
          if (step_cnt_q + 1'b1 == k_len_q) state_d = S_STORE;
        end
      end
      S_STORE: begin
        z_push_o   = 1'b1;
        job_done_o = z_ready_i;
        if (z_ready_i) state_d = S_IDLE;
      end
      default: state_d = S_IDLE;
    endcase
  end

  // X and W always leave their FIFOs as a pair
  assign x_pop_o = step;
  assign w_pop_o = step;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= S_IDLE;
      k_len_q    <= KLEN_W'(1);
      step_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == S_IDLE && start_i) begin
        k_len_q    <= k_len_i;
        step_cnt_q <= '0;
      end else if (step) begin
        step_cnt_q <= step_cnt_q + 1'b1;
      end
    end
  end

  // Exactly K steps are taken before the result leaves
  a_k_steps : assert property (@(posedge clk_i) disable iff (reset_i)
    job_done_o |-> step_cnt_q == k_len_q);

endmodule : redmule_scheduler

//--- hdl/redmule_stream_fifo.sv
// First-word-fall-through valid/ready FIFO.
// push_ready_o is low only when full and pop_valid_o only when empty.
// A push into an empty FIFO is visible at the pop side one cycle later.

`timescale 1ns/1ps

module redmule_stream_fifo #(
  parameter int unsigned DATA_W = 32,
  parameter int unsigned DEPTH  = 4
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              push_valid_i,
  input  logic [DATA_W-1:0] push_data_i,
  output logic              push_ready_o,
  output logic              pop_valid_o,
  output logic [DATA_W-1:0] pop_data_o,
  input  logic              pop_ready_i
);

  logic [DATA_W-1:0]          mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(DEPTH):0]     count_q;
  logic                       push_en;
  logic                       pop_en;

  assign push_ready_o = (count_q < DEPTH);
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push_en = push_valid_i & push_ready_o;
  assign pop_en  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (push_en) mem_q[wr_ptr_q] <= push_data_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      if (pop_en)  rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      case ({push_en, pop_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // A full FIFO takes no write until something leaves
  a_no_push_full : assert property (@(posedge clk_i) disable iff (reset_i)
    (count_q == DEPTH) && !pop_en |=> count_q == DEPTH);

  // An empty FIFO gives no read until something arrives
  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (reset_i)
    (count_q == '0) && !push_en |=> count_q == '0);

endmodule : redmule_stream_fifo

//--- hdl/redmule_top.sv
// Integer MAC tile: Z = Y + X*W over K steps for ROWS rows.
// Configured over APB. X, W and Y enter through FIFOs; Z leaves through one.
// evt_o pulses once per job, the cycle after Z is pushed into the output FIFO.

`timescale 1ns/1ps

module redmule_top
  import redmule_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [APB_ADDR_W-1:0] paddr_i,
  input  logic [APB_DATA_W-1:0] pwdata_i,
  output logic [APB_DATA_W-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  input  logic                  x_valid_i,
  input  logic [X_W-1:0]        x_data_i,
  output logic                  x_ready_o,
  input  logic                  w_valid_i,
  input  logic [ELEM_W-1:0]     w_data_i,
  output logic                  w_ready_o,
  input  logic                  y_valid_i,
  input  logic [YZ_W-1:0]       y_data_i,
  output logic                  y_ready_o,
  output logic                  z_valid_o,
  output logic [YZ_W-1:0]       z_data_o,
  input  logic                  z_ready_i,
  output logic                  evt_o
);

  logic              start;
  logic              job_done;
  logic [KLEN_W-1:0] k_len;
  engine_op_e        eng_op;
  logic              x_fifo_valid, w_fifo_valid, y_fifo_valid;
  logic              x_pop, w_pop, y_pop;
  logic              z_push, z_fifo_ready;
  logic [X_W-1:0]    x_fifo_data;
  logic [ELEM_W-1:0] w_fifo_data;
  logic [YZ_W-1:0]   y_fifo_data;
  logic [YZ_W-1:0]   eng_z_data;

  redmule_ctrl i_ctrl (
    .clk_i, .reset_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .job_done_i ( job_done ),
    .prdata_o, .pready_o, .pslverr_o,
    .start_o    ( start    ),
    .k_len_o    ( k_len    ),
    .evt_o
  );

  redmule_scheduler i_scheduler (
    .clk_i, .reset_i,
    .start_i    ( start        ),
    .k_len_i    ( k_len        ),
    .x_valid_i  ( x_fifo_valid ),
    .w_valid_i  ( w_fifo_valid ),
    .y_valid_i  ( y_fifo_valid ),
    .z_ready_i  ( z_fifo_ready ),
    .x_pop_o    ( x_pop        ),
    .w_pop_o    ( w_pop        ),
    .y_pop_o    ( y_pop        ),
    .z_push_o   ( z_push       ),
    .eng_op_o   ( eng_op       ),
    .job_done_o ( job_done     )
  );

  redmule_stream_fifo #(.DATA_W(X_W), .DEPTH(IN_FIFO_DEPTH)) i_x_fifo (
    .clk_i, .reset_i,
    .push_valid_i ( x_valid_i    ), .push_data_i ( x_data_i    ), .push_ready_o ( x_ready_o ),
    .pop_valid_o  ( x_fifo_valid ), .pop_data_o  ( x_fifo_data ), .pop_ready_i  ( x_pop     )
  );

  redmule_stream_fifo #(.DATA_W(ELEM_W), .DEPTH(IN_FIFO_DEPTH)) i_w_fifo (
    .clk_i, .reset_i,
    .push_valid_i ( w_valid_i    ), .push_data_i ( w_data_i    ), .push_ready_o ( w_ready_o ),
    .pop_valid_o  ( w_fifo_valid ), .pop_data_o  ( w_fifo_data ), .pop_ready_i  ( w_pop     )
  );

  redmule_stream_fifo #(.DATA_W(YZ_W), .DEPTH(IN_FIFO_DEPTH)) i_y_fifo (
    .clk_i, .reset_i,
    .push_valid_i ( y_valid_i    ), .push_data_i ( y_data_i    ), .push_ready_o ( y_ready_o ),
    .pop_valid_o  ( y_fifo_valid ), .pop_data_o  ( y_fifo_data ), .pop_ready_i  ( y_pop     )
  );

  // Result FIFO, back-pressured by z_ready_i
  redmule_stream_fifo #(.DATA_W(YZ_W), .DEPTH(OUT_FIFO_DEPTH)) i_z_fifo (
    .clk_i, .reset_i,
    .push_valid_i ( z_push    ), .push_data_i ( eng_z_data ), .push_ready_o ( z_fifo_ready ),
    .pop_valid_o  ( z_valid_o ), .pop_data_o  ( z_data_o   ), .pop_ready_i  ( z_ready_i    )
  );

  redmule_engine i_engine (
    .clk_i, .reset_i,
    .eng_op_i ( eng_op      ),
    .x_data_i ( x_fifo_data ),
    .w_data_i ( w_fifo_data ),
    .y_data_i ( y_fifo_data ),
    .z_data_o ( eng_z_data  )
  );

endmodule : redmule_top

//--- src.f
hdl/redmule_pkg.sv
hdl/redmule_stream_fifo.sv
hdl/redmule_engine.sv
hdl/redmule_scheduler.sv
hdl/redmule_ctrl.sv
hdl/redmule_top.sv
verification/tb_redmule.sv

//--- verification/tb_redmule.sv
// Self-checking testbench for the MAC tile.
// Register checks and jobs come from tables. Operands and Z back-pressure use $random.
// Expected Z is rebuilt here from the wrap rule, modulo 2^ACC_W per row.

`timescale 1ns/1ps

module tb_redmule
  import redmule_pkg::*;
();

  localparam int NUM_REG  = 8;
  localparam int NUM_JOBS = 5;

  // Register accesses: offset, write flag, write data, expected read data, expected pslverr
  logic [APB_ADDR_W-1:0] reg_addr  [NUM_REG] = '{REG_KLEN, REG_KLEN, REG_KLEN, REG_KLEN,
                                                 REG_STATUS, REG_STATUS, 8'h10, 8'h10};
  bit                    reg_write [NUM_REG] = '{1, 0, 1, 0, 1, 0, 0, 1};
  logic [APB_DATA_W-1:0] reg_wdata [NUM_REG] = '{5, 0, 0, 0, 1, 0, 0, 7};
  logic [APB_DATA_W-1:0] reg_rdata [NUM_REG] = '{0, 5, 0, 1, 0, 0, 0, 0};
  bit                    reg_err   [NUM_REG] = '{0, 0, 0, 0, 1, 0, 1, 1};

  // Jobs: depth K and whether Z sees back-pressure
  int job_klen [NUM_JOBS] = '{1, 3, 8, 255, 16};
  bit job_bp   [NUM_JOBS] = '{0, 0, 1, 0, 1};

  logic                  clk_i;
  logic                  reset_i;
  logic                  psel_i;
  logic                  penable_i;
  logic                  pwrite_i;
  logic [APB_ADDR_W-1:0] paddr_i;
  logic [APB_DATA_W-1:0] pwdata_i;
  logic [APB_DATA_W-1:0] prdata_o;
  logic                  pready_o;
  logic                  pslverr_o;
  logic                  x_valid_i;
  logic [X_W-1:0]        x_data_i;
  logic                  x_ready_o;
  logic                  w_valid_i;
  logic [ELEM_W-1:0]     w_data_i;
  logic                  w_ready_o;
  logic                  y_valid_i;
  logic [YZ_W-1:0]       y_data_i;
  logic                  y_ready_o;
  logic                  z_valid_o;
  logic [YZ_W-1:0]       z_data_o;
  logic                  z_ready_i;
  logic                  evt_o;

  integer          seed      = 3029;
  int              checks    = 0;
  int              errors    = 0;
  int              z_count   = 0;
  int              evt_count = 0;
  int              cycles    = 0;
  int              cycle_limit;
  logic            z_stalled = 1'b0;
  logic [YZ_W-1:0] z_held;
  logic [YZ_W-1:0] z_last;
  logic [YZ_W-1:0] z_exp;

  redmule_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                             input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // One zero-wait APB transfer, setup phase then access phase
  task automatic apb_access(input logic write, input logic [APB_ADDR_W-1:0] addr,
                            input logic [APB_DATA_W-1:0] wdata,
                            output logic [APB_DATA_W-1:0] rdata, output logic err);
    @(posedge clk_i);
    #1;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(posedge clk_i);
    #1;
    penable_i = 1'b1;
    @(negedge clk_i);
    check_value(pready_o, 1'b1, "pready_o in access phase");
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge clk_i);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic send_y(input logic [YZ_W-1:0] y);
    logic done;
    y_valid_i = 1'b1;
    y_data_i  = y;
    done      = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      done = y_ready_o;
      @(posedge clk_i);
      #1;
    end
    y_valid_i = 1'b0;
  endtask

  // X and W are offered together, each drops valid once it has transferred
  task automatic send_xw(input logic [X_W-1:0] x, input logic [ELEM_W-1:0] w);
    logic x_done;
    logic w_done;
    x_valid_i = 1'b1;
    x_data_i  = x;
    w_valid_i = 1'b1;
    w_data_i  = w;
    while (x_valid_i || w_valid_i) begin
      @(negedge clk_i);
      x_done = x_ready_o;
      w_done = w_ready_o;
      @(posedge clk_i);
      #1;
      if (x_done) x_valid_i = 1'b0;
      if (w_done) w_valid_i = 1'b0;
    end
  endtask

  task automatic drive_operands(input int k);
    logic [ACC_W-1:0]  acc [ROWS];
    logic [YZ_W-1:0]   y;
    logic [X_W-1:0]    x;
    logic [ELEM_W-1:0] w;
    int                prod;
    for (int r = 0; r < ROWS; r++) begin
      acc[r] = $random(seed);
      y[r*ACC_W +: ACC_W] = acc[r];
    end
    send_y(y);
    for (int s = 0; s < k; s++) begin
      x = $random(seed);
      w = $random(seed);
      for (int r = 0; r < ROWS; r++) begin
        prod   = $signed(x[r*ELEM_W +: ELEM_W]) * $signed(w);
        acc[r] = acc[r] + prod[ACC_W-1:0];
      end
      send_xw(x, w);
    end
    for (int r = 0; r < ROWS; r++) z_exp[r*ACC_W +: ACC_W] = acc[r];
  endtask

  // Random draws happen at the falling edge, away from the operand draws
  task automatic collect_z(input bit bp, input int base);
    bit hold;
    while (z_count == base) begin
      @(negedge clk_i);
      hold = bp && (($random(seed) & 7) != 0);
      @(posedge clk_i);
      #1;
      z_ready_i = !hold;
    end
    z_ready_i = 1'b1;
  endtask

  task automatic run_job(input int k, input bit bp);
    logic [APB_DATA_W-1:0] rdata;
    logic                  err;
    int                    z_base;
    int                    evt_base;
    apb_access(1'b1, REG_KLEN, k, rdata, err);
    check_value(err, 0, "pslverr_o on depth write");
    apb_access(1'b1, REG_TRIGGER, 1, rdata, err);
    check_value(err, 0, "pslverr_o on trigger");
    apb_access(1'b0, REG_STATUS, 0, rdata, err);
    check_value(rdata[0], 1, "busy bit during job");
    apb_access(1'b1, REG_TRIGGER, 1, rdata, err);
    check_value(err, 1, "pslverr_o on trigger while busy");
    z_base   = z_count;
    evt_base = evt_count;
    fork
      drive_operands(k);
      collect_z(bp, z_base);
    join
    wait (evt_count != evt_base);
    repeat (2) @(posedge clk_i);
    apb_access(1'b0, REG_STATUS, 0, rdata, err);
    check_value(rdata[0], 0, "busy bit after event");
    check_value(z_count, z_base + 1, "Z beats of one job");
    check_value(evt_count, evt_base + 1, "events of one job");
    check_value(z_last, z_exp, $sformatf("Z data for K=%0d", k));
  endtask

  // Count Z transfers and events, and check that a stalled Z beat holds still
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (z_stalled) begin
        check_value(z_valid_o, 1'b1, "z_valid_o dropped while stalled");
        check_value(z_data_o, z_held, "z_data_o changed while stalled");
      end
      z_stalled = z_valid_o & ~z_ready_i;
      z_held    = z_data_o;
      if (z_valid_o && z_ready_i) begin
        z_count++;
        z_last = z_data_o;
      end
      if (evt_o) evt_count++;
    end
  end

  initial begin
    cycle_limit = 200;
    for (int j = 0; j < NUM_JOBS; j++) cycle_limit += 4 * (job_klen[j] + 4);
    forever begin
      @(posedge clk_i);
      cycles++;
      if (cycles > cycle_limit) begin
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("FAIL: see errors above");
        $finish;
      end
    end
  end

  initial begin
    logic [APB_DATA_W-1:0] rdata;
    logic                  err;
    reset_i   = 1'b1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    x_valid_i = 1'b0;
    x_data_i  = '0;
    w_valid_i = 1'b0;
    w_data_i  = '0;
    y_valid_i = 1'b0;
    y_data_i  = '0;
    z_ready_i = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    // Idle outputs right after reset
    check_value(x_ready_o, 1'b1, "x_ready_o after reset");
    check_value(w_ready_o, 1'b1, "w_ready_o after reset");
    check_value(y_ready_o, 1'b1, "y_ready_o after reset");
    check_value(z_valid_o, 1'b0, "z_valid_o after reset");
    check_value(evt_o, 1'b0, "evt_o after reset");
    for (int i = 0; i < NUM_REG; i++) begin
      apb_access(reg_write[i], reg_addr[i], reg_wdata[i], rdata, err);
      check_value(err, reg_err[i], $sformatf("pslverr_o of register access %0d", i));
      if (!reg_write[i] && !reg_err[i]) begin
        check_value(rdata, reg_rdata[i], $sformatf("read data of register access %0d", i));
      end
    end
    for (int j = 0; j < NUM_JOBS; j++) run_job(job_klen[j], job_bp[j]);
    check_value(z_count, NUM_JOBS, "total Z beats");
    check_value(evt_count, NUM_JOBS, "total events");
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule : tb_redmule
